//--- run_sim.sh
#!/bin/sh
# build and run the 1R2W memory testbench with Verilator.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f verilog.f \
  --top-module tb_mem_1r2w \
  -Mdir "$BUILD_DIR" -o tb_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$BUILD_DIR/tb_sim" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Result: FAILED" "$LOG"; then
  echo "simulation reported a failure, see $LOG"
  exit 1
fi

if [ $run_status -ne 0 ]; then
  echo "simulator exited with status $run_status"
  exit 1
fi

exit 0

//--- verilog.f
+incdir+verilog
verilog/mem_pkg.sv
verilog/mem_input_stage.sv
verilog/mem_port_wrap.sv
verilog/mem_1r2w_array.sv
verilog/mem_1r2w_top.sv
tests/tb_mem_1r2w.sv

//--- tests/tb_mem_1r2w.sv
`timescale 1ns/1ps
`include "mem_settings.svh"

module tb_mem_1r2w;

  localparam int W            = `MEM_WIDTH;
  localparam int BA           = `MEM_BITADDR;
  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 3;
  localparam int LATENCY      = `MEM_FLOPIN + `MEM_SRAM_DELAY + `MEM_FLOPOUT;
  localparam int RAND_CYCLES  = 64;
  localparam int TEST_CYCLES  = RESET_CYCLES + 4 + `MEM_NUMADDR / 2 + RAND_CYCLES
                                + 6 * (LATENCY + 12);
  localparam int WATCHDOG_CYCLES = TEST_CYCLES + 50;
  localparam logic [W-1:0] FULL_MASK = '1;

  logic                             clk;
  logic                             reset;
  logic [`MEM_NUMRDPRT-1:0]         read;
  logic [`MEM_NUMRDPRT*BA-1:0]      rd_adr;
  logic [`MEM_NUMWRPRT-1:0]         write;
  logic [`MEM_NUMWRPRT*BA-1:0]      wr_adr;
  logic [`MEM_NUMWRPRT*W-1:0]       din;
  logic [`MEM_NUMWRPRT*W-1:0]       bw;
  logic [`MEM_NUMRDPRT*W-1:0]       rd_dout;
  logic [`MEM_NUMRDPRT-1:0]         rd_vld;

  logic [W-1:0] ref_mem [`MEM_NUMADDR];
  logic [W-1:0] exp_q [$]; // expected read words, oldest first.
  int           iss_q [$]; // cycle in which each read was issued.
  int           cyc;
  logic [16:0]  lfsr_state;

  mem_1r2w_top u_dut (
    .clk     (clk),
    .reset   (reset),
    .read    (read),
    .rd_adr  (rd_adr),
    .write   (write),
    .wr_adr  (wr_adr),
    .din     (din),
    .bw      (bw),
    .rd_dout (rd_dout),
    .rd_vld  (rd_vld)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  always @(posedge clk) cyc <= cyc + 1;

  // ##################################################
  // failure reporting and checks.
  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Result: FAILED");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      stop_run($sformatf("FAIL %s: got 0x%0h, expected 0x%0h", name, actual, expected));
    end
  endtask

  // ##################################################
  // stimulus helpers.
  function automatic logic lfsr_step();
    logic fb;
    fb = lfsr_state[16] ^ lfsr_state[13]; // x^17 + x^14 + 1.
    lfsr_state = {lfsr_state[15:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val = {val[30:0], lfsr_step()};
    end
    return val;
  endfunction

  function automatic logic [W-1:0] rand_word();
    logic [31:0] raw;
    raw = take_bits(W);
    return raw[W-1:0];
  endfunction

  function automatic logic [BA-1:0] rand_addr();
    logic [31:0] raw;
    raw = take_bits(BA) % `MEM_NUMADDR;
    return raw[BA-1:0];
  endfunction

  // each set mask bit takes the new bit, every other bit keeps the old one.
  function automatic logic [W-1:0] merge_bits(input logic [W-1:0] old_w,
                                              input logic [W-1:0] new_w,
                                              input logic [W-1:0] mask);
    logic [W-1:0] res;
    for (int i = 0; i < W; i++) begin
      res[i] = mask[i] ? new_w[i] : old_w[i];
    end
    return res;
  endfunction

  function automatic logic [W-1:0] fill_word(input int a);
    logic [7:0] av;
    av = a[7:0];
    return {av, av[6:0] ^ 7'h2b};
  endfunction

  // one command cycle. the read sees the memory before this cycle's writes.
  task automatic drive_cycle(input logic rd_en, input logic [BA-1:0] ra,
                             input logic [1:0] wr_en,
                             input logic [BA-1:0] wa_a, input logic [BA-1:0] wa_b,
                             input logic [W-1:0] da, input logic [W-1:0] db,
                             input logic [W-1:0] ma, input logic [W-1:0] mb);
    read   = rd_en;
    rd_adr = ra;
    write  = wr_en;
    wr_adr = {wa_b, wa_a};
    din    = {db, da};
    bw     = {mb, ma};
    if (rd_en) begin
      exp_q.push_back(ref_mem[ra]);
      iss_q.push_back(cyc);
    end
    if (wr_en[0]) ref_mem[wa_a] = merge_bits(ref_mem[wa_a], da, ma);
    if (wr_en[1]) ref_mem[wa_b] = merge_bits(ref_mem[wa_b], db, mb); // B lands on top of A.
    @(negedge clk);
  endtask

  task automatic idle_cycles(input int n);
    read  = '0;
    write = '0;
    repeat (n) @(negedge clk);
  endtask

  task automatic drain_reads();
    int waited;
    waited = 0;
    idle_cycles(0);
    while (exp_q.size() != 0) begin
      if (waited > LATENCY + 4) stop_run("read data did not come back in time");
      @(negedge clk);
      waited++;
    end
  endtask

  // outputs come from flops, so the falling edge sees them settled.
  always @(negedge clk) begin
    if (rd_vld[0] === 1'b1) begin
      if (exp_q.size() == 0) begin
        stop_run("rd_vld went high with no read outstanding");
      end else begin
        check_value("rd_dout", rd_dout, exp_q.pop_front());
        check_value("rd_latency", cyc - iss_q.pop_front(), LATENCY);
      end
    end
  end

  // ##################################################
  // directed tests.
  task automatic test_reset_state();
    repeat (RESET_CYCLES) begin
      @(negedge clk);
      check_value("rd_vld", rd_vld, 0);
    end
    reset = 1'b0;
    repeat (4) begin
      @(negedge clk);
      check_value("rd_vld", rd_vld, 0);
    end
  endtask

  task automatic fill_memory();
    for (int a = 0; a < `MEM_NUMADDR; a += 2) begin
      drive_cycle(1'b0, '0, 2'b11, BA'(a), BA'(a + 1), fill_word(a), fill_word(a + 1),
                  FULL_MASK, FULL_MASK);
    end
    idle_cycles(1);
  endtask

  task automatic test_single_port();
    drive_cycle(1'b0, '0, 2'b01, 8'd10, '0, rand_word(), '0, FULL_MASK, '0);
    drive_cycle(1'b0, '0, 2'b10, '0, 8'd20, '0, rand_word(), '0, FULL_MASK);
    drive_cycle(1'b1, 8'd10, 2'b00, '0, '0, '0, '0, '0, '0);
    drive_cycle(1'b1, 8'd20, 2'b00, '0, '0, '0, '0, '0, '0);
    drain_reads();
  endtask

  task automatic test_partial_masks();
    for (int i = 0; i < 4; i++) begin
      if (i % 2 == 0) begin
        drive_cycle(1'b0, '0, 2'b01, 8'd37, '0, rand_word(), '0, rand_word(), '0);
      end else begin
        drive_cycle(1'b0, '0, 2'b10, '0, 8'd37, '0, rand_word(), '0, rand_word());
      end
      drive_cycle(1'b1, 8'd37, 2'b00, '0, '0, '0, '0, '0, '0);
    end
    drain_reads();
  endtask

  task automatic test_same_address();
    logic [W-1:0] da;
    da = rand_word();
    // port B carries the inverse of port A, so every shared mask bit shows which write won.
    drive_cycle(1'b0, '0, 2'b11, 8'd100, 8'd100, da, ~da,
                15'h0ff0, 15'h3fc0);
    drive_cycle(1'b1, 8'd100, 2'b00, '0, '0, '0, '0, '0, '0);
    drain_reads();
  endtask

  task automatic test_read_during_write();
    logic [W-1:0] new_w;
    new_w = ~ref_mem[150];
    drive_cycle(1'b1, 8'd150, 2'b01, 8'd150, '0, new_w, '0, FULL_MASK, '0);
    drive_cycle(1'b1, 8'd150, 2'b00, '0, '0, '0, '0, '0, '0);
    drain_reads();
  endtask

  task automatic test_random_traffic();
    logic [31:0] en;
    for (int i = 0; i < RAND_CYCLES; i++) begin
      en = take_bits(2);
      drive_cycle(1'b1, rand_addr(), en[1:0], rand_addr(), rand_addr(),
                  rand_word(), rand_word(), rand_word(), rand_word());
    end
    drain_reads();
  endtask

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    stop_run("watchdog expired before the tests finished");
  end

  initial begin
    reset      = 1'b1;
    read       = '0;
    rd_adr     = '0;
    write      = '0;
    wr_adr     = '0;
    din        = '0;
    bw         = '0;
    cyc        = 0;
    lfsr_state = 17'd77536;
    test_reset_state();
    fill_memory();
    test_single_port();
    test_partial_masks();
    test_same_address();
    test_read_during_write();
    test_random_traffic();
    if (exp_q.size() == 0) begin
      $display("Result: PASSED");
      $finish;
    end else begin
      stop_run("reads were still outstanding at the end of the run");
    end
  end

endmodule

//--- verilog/mem_1r2w_top.sv
`timescale 1ns/1ps
`include "mem_settings.svh"

module mem_1r2w_top (
  input  logic                                  clk,
  input  logic                                  reset,
  input  logic [`MEM_NUMRDPRT-1:0]              read,
  input  logic [`MEM_NUMRDPRT*`MEM_BITADDR-1:0] rd_adr,
  input  logic [`MEM_NUMWRPRT-1:0]              write,
  input  logic [`MEM_NUMWRPRT*`MEM_BITADDR-1:0] wr_adr,
  input  logic [`MEM_NUMWRPRT*`MEM_WIDTH-1:0]   din,
  input  logic [`MEM_NUMWRPRT*`MEM_WIDTH-1:0]   bw,
  output logic [`MEM_NUMRDPRT*`MEM_WIDTH-1:0]   rd_dout,
  output logic [`MEM_NUMRDPRT-1:0]              rd_vld
);

  logic [`MEM_NUMRDPRT-1:0]              q_read;
  logic [`MEM_NUMRDPRT*`MEM_BITADDR-1:0] q_rd_adr;
  logic [`MEM_NUMWRPRT-1:0]              q_write;
  logic [`MEM_NUMWRPRT*`MEM_BITADDR-1:0] q_wr_adr;
  logic [`MEM_NUMWRPRT*`MEM_WIDTH-1:0]   q_din;
  logic [`MEM_NUMWRPRT*`MEM_WIDTH-1:0]   q_bw;

  logic                    t1_readC;
  logic [`MEM_BITADDR-1:0] t1_addrC;
  logic [`MEM_WIDTH-1:0]   t1_doutC;
  logic                    t1_writeA;
  logic [`MEM_BITADDR-1:0] t1_addrA;
  logic [`MEM_WIDTH-1:0]   t1_dinA;
  logic [`MEM_WIDTH-1:0]   t1_bwA;
  logic                    t1_writeB;
  logic [`MEM_BITADDR-1:0] t1_addrB;
  logic [`MEM_WIDTH-1:0]   t1_dinB;
  logic [`MEM_WIDTH-1:0]   t1_bwB;

  // ##################################################
  // reads and writes share the input delay, so write ordering holds.
  mem_input_stage #(
    .FLOPIN (`MEM_FLOPIN)
  ) u_input_stage (
    .clk      (clk),
    .reset    (reset),
    .read     (read),
    .rd_adr   (rd_adr),
    .write    (write),
    .wr_adr   (wr_adr),
    .din      (din),
    .bw       (bw),
    .q_read   (q_read),
    .q_rd_adr (q_rd_adr),
    .q_write  (q_write),
    .q_wr_adr (q_wr_adr),
    .q_din    (q_din),
    .q_bw     (q_bw)
  );

  mem_port_wrap #(
    .SRAM_DELAY (`MEM_SRAM_DELAY),
    .FLOPOUT    (`MEM_FLOPOUT)
  ) u_port_wrap (
    .clk       (clk),
    .reset     (reset),
    .read      (q_read),
    .rd_adr    (q_rd_adr),
    .write     (q_write),
    .wr_adr    (q_wr_adr),
    .din       (q_din),
    .bw        (q_bw),
    .t1_doutC  (t1_doutC),
    .rd_dout   (rd_dout),
    .rd_vld    (rd_vld),
    .t1_readC  (t1_readC),
    .t1_addrC  (t1_addrC),
    .t1_writeA (t1_writeA),
    .t1_addrA  (t1_addrA),
    .t1_dinA   (t1_dinA),
    .t1_bwA    (t1_bwA),
    .t1_writeB (t1_writeB),
    .t1_addrB  (t1_addrB),
    .t1_dinB   (t1_dinB),
    .t1_bwB    (t1_bwB)
  );

  mem_1r2w_array #(
    .DELAY (`MEM_SRAM_DELAY)
  ) u_array (
    .clk       (clk),
    .reset     (reset),
    .t1_readC  (t1_readC),
    .t1_addrC  (t1_addrC),
    .t1_doutC  (t1_doutC),
    .t1_writeA (t1_writeA),
    .t1_addrA  (t1_addrA),
    .t1_dinA   (t1_dinA),
    .t1_bwA    (t1_bwA),
    .t1_writeB (t1_writeB),
    .t1_addrB  (t1_addrB),
    .t1_dinB   (t1_dinB),
    .t1_bwB    (t1_bwB)
  );

endmodule

//--- verilog/mem_1r2w_array.sv
`timescale 1ns/1ps
`include "mem_settings.svh"

module mem_1r2w_array #(
  parameter int DELAY = `MEM_SRAM_DELAY
) (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    t1_readC,
  input  logic [`MEM_BITADDR-1:0] t1_addrC,
  output logic [`MEM_WIDTH-1:0]   t1_doutC,
  input  logic                    t1_writeA,
  input  logic [`MEM_BITADDR-1:0] t1_addrA,
  input  logic [`MEM_WIDTH-1:0]   t1_dinA,
  input  logic [`MEM_WIDTH-1:0]   t1_bwA,
  input  logic                    t1_writeB,
  input  logic [`MEM_BITADDR-1:0] t1_addrB,
  input  logic [`MEM_WIDTH-1:0]   t1_dinB,
  input  logic [`MEM_WIDTH-1:0]   t1_bwB
);
  import mem_pkg::*;

  logic [`MEM_WIDTH-1:0]             mem [`MEM_NUMADDR];
  logic [`MEM_MAXPRT*`MEM_WIDTH-1:0] wr_din;
  logic [`MEM_MAXPRT*`MEM_WIDTH-1:0] wr_bw;
  logic [`MEM_WIDTH-1:0]             merged_a;
  logic [`MEM_WIDTH-1:0]             base_b;
  logic [`MEM_WIDTH-1:0]             merged_b;

  assign wr_din = (`MEM_MAXPRT*`MEM_WIDTH)'({t1_dinB, t1_dinA});
  assign wr_bw  = (`MEM_MAXPRT*`MEM_WIDTH)'({t1_bwB, t1_bwA});

  // ##################################################
  // write merge, port A first and port B on top of it.
  always_comb begin
    merged_a = bw_merge(mem[t1_addrA], lane_word(wr_din, 0), lane_word(wr_bw, 0));
    if (t1_writeA && (t1_addrA == t1_addrB)) begin
      base_b = merged_a; // B sees the word as A left it.
    end else begin
      base_b = mem[t1_addrB];
    end
    merged_b = bw_merge(base_b, lane_word(wr_din, 1), lane_word(wr_bw, 1));
  end

  always_ff @(posedge clk) begin
    if (t1_writeA) begin
      mem[t1_addrA] <= merged_a;
    end
    if (t1_writeB) begin
      mem[t1_addrB] <= merged_b; // last update wins on a shared address.
    end
  end

  // ##################################################
  // read path. the word is sampled before this edge's writes land.
  if (DELAY > 0) begin : g_dly
    logic [`MEM_WIDTH-1:0] rd_pipe [DELAY];

    always_ff @(posedge clk) begin
      if (t1_readC) begin
        rd_pipe[0] <= mem[t1_addrC];
      end
      for (int i = 1; i < DELAY; i++) begin
        rd_pipe[i] <= rd_pipe[i-1];
      end
    end
    assign t1_doutC = rd_pipe[DELAY-1];
  end else begin : g_no_dly
    assign t1_doutC = mem[t1_addrC];
  end

  // an illegal address here means the wrapper mapped a lane wrongly
  // or a master slipped past the input checks.
  a_rd_range: assert property (@(posedge clk) disable iff (reset)
    t1_readC |-> (t1_addrC < `MEM_NUMADDR));

  a_wr_a_range: assert property (@(posedge clk) disable iff (reset)
    t1_writeA |-> (t1_addrA < `MEM_NUMADDR));

  a_wr_b_range: assert property (@(posedge clk) disable iff (reset)
    t1_writeB |-> (t1_addrB < `MEM_NUMADDR));

endmodule

//--- verilog/mem_port_wrap.sv
`timescale 1ns/1ps
`include "mem_settings.svh"

module mem_port_wrap #(
  parameter int SRAM_DELAY = `MEM_SRAM_DELAY,
  parameter int FLOPOUT    = `MEM_FLOPOUT
) (
  input  logic                                  clk,
  input  logic                                  reset,
  input  logic [`MEM_NUMRDPRT-1:0]              read,
  input  logic [`MEM_NUMRDPRT*`MEM_BITADDR-1:0] rd_adr,
  input  logic [`MEM_NUMWRPRT-1:0]              write,
  input  logic [`MEM_NUMWRPRT*`MEM_BITADDR-1:0] wr_adr,
  input  logic [`MEM_NUMWRPRT*`MEM_WIDTH-1:0]   din,
  input  logic [`MEM_NUMWRPRT*`MEM_WIDTH-1:0]   bw,
  input  logic [`MEM_WIDTH-1:0]                 t1_doutC,
  output logic [`MEM_NUMRDPRT*`MEM_WIDTH-1:0]   rd_dout,
  output logic [`MEM_NUMRDPRT-1:0]              rd_vld,
  output logic                                  t1_readC,
  output logic [`MEM_BITADDR-1:0]               t1_addrC,
  output logic                                  t1_writeA,
  output logic [`MEM_BITADDR-1:0]               t1_addrA,
  output logic [`MEM_WIDTH-1:0]                 t1_dinA,
  output logic [`MEM_WIDTH-1:0]                 t1_bwA,
  output logic                                  t1_writeB,
  output logic [`MEM_BITADDR-1:0]               t1_addrB,
  output logic [`MEM_WIDTH-1:0]                 t1_dinB,
  output logic [`MEM_WIDTH-1:0]                 t1_bwB
);
  import mem_pkg::*;

  localparam int VLD_DEPTH = SRAM_DELAY + FLOPOUT;

  logic [`MEM_MAXPRT*`MEM_BITADDR-1:0] rd_adr_ext;
  logic [`MEM_MAXPRT*`MEM_BITADDR-1:0] wr_adr_ext;
  logic [`MEM_MAXPRT*`MEM_WIDTH-1:0]   din_ext;
  logic [`MEM_MAXPRT*`MEM_WIDTH-1:0]   bw_ext;
  logic [`MEM_NUMRDPRT*`MEM_WIDTH-1:0] rd_dout_raw;

  assign rd_adr_ext = (`MEM_MAXPRT*`MEM_BITADDR)'(rd_adr);
  assign wr_adr_ext = (`MEM_MAXPRT*`MEM_BITADDR)'(wr_adr);
  assign din_ext    = (`MEM_MAXPRT*`MEM_WIDTH)'(din);
  assign bw_ext     = (`MEM_MAXPRT*`MEM_WIDTH)'(bw);

  // ##################################################
  // lane to physical port mapping.
  always_comb begin
    t1_readC  = read[0];
    t1_addrC  = lane_addr(rd_adr_ext, 0);

    t1_writeA = write[0]; // lane 0 drives port A.
    t1_addrA  = lane_addr(wr_adr_ext, 0);
    t1_dinA   = lane_word(din_ext, 0);
    t1_bwA    = lane_word(bw_ext, 0);

    t1_writeB = write[1]; // lane 1 drives port B.
    t1_addrB  = lane_addr(wr_adr_ext, 1);
    t1_dinB   = lane_word(din_ext, 1);
    t1_bwB    = lane_word(bw_ext, 1);
  end

  assign rd_dout_raw = (`MEM_NUMRDPRT*`MEM_WIDTH)'(t1_doutC);

  // ##################################################
  // output alignment.
  if (VLD_DEPTH > 0) begin : g_vld
    logic [`MEM_NUMRDPRT-1:0] vld_pipe [VLD_DEPTH];

    always_ff @(posedge clk) begin
      if (reset) begin
        for (int i = 0; i < VLD_DEPTH; i++) begin
          vld_pipe[i] <= '0;
        end
      end else begin
        vld_pipe[0] <= read;
        for (int i = 1; i < VLD_DEPTH; i++) begin
          vld_pipe[i] <= vld_pipe[i-1];
        end
      end
    end
    assign rd_vld = vld_pipe[VLD_DEPTH-1];
  end else begin : g_no_vld
    assign rd_vld = read;
  end

  // the array already covers SRAM_DELAY, so data only needs the output flops.
  if (FLOPOUT > 0) begin : g_dout
    logic [`MEM_NUMRDPRT*`MEM_WIDTH-1:0] dout_pipe [FLOPOUT];

    always_ff @(posedge clk) begin
      dout_pipe[0] <= rd_dout_raw;
      for (int i = 1; i < FLOPOUT; i++) begin
        dout_pipe[i] <= dout_pipe[i-1];
      end
    end
    assign rd_dout = dout_pipe[FLOPOUT-1];
  end else begin : g_no_dout
    assign rd_dout = rd_dout_raw;
  end

  a_dout_known: assert property (@(posedge clk) disable iff (reset)
    (|rd_vld) |-> !$isunknown(rd_dout));

endmodule

//--- verilog/mem_input_stage.sv
`timescale 1ns/1ps
`include "mem_settings.svh"

module mem_input_stage #(
  parameter int FLOPIN = `MEM_FLOPIN
) (
  input  logic                                  clk,
  input  logic                                  reset,
  input  logic [`MEM_NUMRDPRT-1:0]              read,
  input  logic [`MEM_NUMRDPRT*`MEM_BITADDR-1:0] rd_adr,
  input  logic [`MEM_NUMWRPRT-1:0]              write,
  input  logic [`MEM_NUMWRPRT*`MEM_BITADDR-1:0] wr_adr,
  input  logic [`MEM_NUMWRPRT*`MEM_WIDTH-1:0]   din,
  input  logic [`MEM_NUMWRPRT*`MEM_WIDTH-1:0]   bw,
  output logic [`MEM_NUMRDPRT-1:0]              q_read,
  output logic [`MEM_NUMRDPRT*`MEM_BITADDR-1:0] q_rd_adr,
  output logic [`MEM_NUMWRPRT-1:0]              q_write,
  output logic [`MEM_NUMWRPRT*`MEM_BITADDR-1:0] q_wr_adr,
  output logic [`MEM_NUMWRPRT*`MEM_WIDTH-1:0]   q_din,
  output logic [`MEM_NUMWRPRT*`MEM_WIDTH-1:0]   q_bw
);
  import mem_pkg::*;

  logic [`MEM_MAXPRT*`MEM_BITADDR-1:0] rd_adr_ext;
  logic [`MEM_MAXPRT*`MEM_BITADDR-1:0] wr_adr_ext;

  assign rd_adr_ext = (`MEM_MAXPRT*`MEM_BITADDR)'(rd_adr);
  assign wr_adr_ext = (`MEM_MAXPRT*`MEM_BITADDR)'(wr_adr);

  // ##################################################
  // command register.
  if (FLOPIN != 0) begin : g_flop
    always_ff @(posedge clk) begin
      if (reset) begin
        q_read  <= '0;
        q_write <= '0;
      end else begin
        q_read  <= read;
        q_write <= write;
      end
    end

    always_ff @(posedge clk) begin
      q_rd_adr <= rd_adr;
      q_wr_adr <= wr_adr;
      q_din    <= din;
      q_bw     <= bw;
    end
  end else begin : g_pass
    assign q_read   = read;
    assign q_rd_adr = rd_adr;
    assign q_write  = write;
    assign q_wr_adr = wr_adr;
    assign q_din    = din;
    assign q_bw     = bw;
  end

  // ##################################################
  // masters must stay inside the populated address range.
  for (genvar r = 0; r < `MEM_NUMRDPRT; r++) begin : g_rd_chk
    a_rd_adr_legal: assert property (@(posedge clk) disable iff (reset)
      read[r] |-> (lane_addr(rd_adr_ext, r) < `MEM_NUMADDR));
  end

  for (genvar w = 0; w < `MEM_NUMWRPRT; w++) begin : g_wr_chk
    a_wr_adr_legal: assert property (@(posedge clk) disable iff (reset)
      write[w] |-> (lane_addr(wr_adr_ext, w) < `MEM_NUMADDR));
  end

endmodule

//--- verilog/mem_pkg.sv
`include "mem_settings.svh"

package mem_pkg;

  // lane buses are sized for the wider of the read and write port sets.
  function automatic logic [`MEM_BITADDR-1:0] lane_addr(
    input logic [`MEM_MAXPRT*`MEM_BITADDR-1:0] bus,
    input int unsigned lane
  );
    return bus[lane*`MEM_BITADDR +: `MEM_BITADDR];
  endfunction

  function automatic logic [`MEM_WIDTH-1:0] lane_word(
    input logic [`MEM_MAXPRT*`MEM_WIDTH-1:0] bus,
    input int unsigned lane
  );
    return bus[lane*`MEM_WIDTH +: `MEM_WIDTH];
  endfunction

  // bits set in the mask take the new data, the rest keep the old word.
  function automatic logic [`MEM_WIDTH-1:0] bw_merge(
    input logic [`MEM_WIDTH-1:0] old_word,
    input logic [`MEM_WIDTH-1:0] new_word,
    input logic [`MEM_WIDTH-1:0] mask
  );
    logic [`MEM_WIDTH-1:0] merged;
    merged = (old_word & ~mask) | (new_word & mask);
    return merged;
  endfunction

endpackage

//--- verilog/mem_settings.svh
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// ##################################################
// word and address geometry.
`define MEM_WIDTH      15
`define MEM_BITADDR    8
`define MEM_NUMADDR    192

// ##################################################
// port counts.
`define MEM_NUMRDPRT   1
`define MEM_NUMWRPRT   2
`define MEM_MAXPRT     ((`MEM_NUMRDPRT > `MEM_NUMWRPRT) ? `MEM_NUMRDPRT : `MEM_NUMWRPRT)

// ##################################################
// pipeline depths in clock cycles.
`define MEM_FLOPIN     1
`define MEM_SRAM_DELAY 1
`define MEM_FLOPOUT    1

`endif
